// ==== filelist.f ====
+incdir+source
source/prf_pkg.sv
source/uop_pkg.sv
source/lead_count.sv
source/int_alu.sv
source/phys_regfile.sv
source/exec_ctrl.sv
source/exec_top.sv
verif/exec_asserts.sv
verif/exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_tb -f filelist.f -o exec_sim

# the simulator status is ignored, the pass line decides
sim_out="$(./obj_dir/exec_sim 2>&1 || true)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASSED"

// ==== source/exec_ctrl.sv ====
`timescale 1ns/100ps

module exec_ctrl (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    output logic              issue_ready,
    input  uop_pkg::uop_t     issue_uop,
    output logic              cpl_valid,
    input  logic              cpl_ready,
    output uop_pkg::cpl_t     cpl,
    output uop_pkg::uop_t     e_uop,
    output prf_pkg::prf_raddr_t raddr,
    input  uop_pkg::cpl_t     e_result,
    output prf_pkg::bypass_t  bypass,
    output prf_pkg::prf_wr_t  prf_wr
);

    import prf_pkg::*;
    import uop_pkg::*;

    typedef enum logic {
        W_EMPTY,
        W_FULL
    } ctrl_state_e;

    ctrl_state_e w_state;
    cpl_t        w_rec;
    logic        e_valid;
    logic        run;        // low until the first edge after reset
    logic        issue_fire;
    logic        w_done;
    logic        w_load;

    assign w_done     = (w_state == W_FULL) && cpl_ready;
    assign w_load     = e_valid && ((w_state == W_EMPTY) || cpl_ready);
    assign issue_ready = run && (!e_valid || w_load);
    assign issue_fire = issue_valid && issue_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run     <= 1'b0;
            e_valid <= 1'b0;
            w_state <= W_EMPTY;
        end else begin
            run <= 1'b1;
            if (issue_fire)
                e_valid <= 1'b1;
            else if (w_load)
                e_valid <= 1'b0;
            if (w_load)
                w_state <= W_FULL;
            else if (w_done)
                w_state <= W_EMPTY;
        end
    end

    // stage payloads
    always_ff @(posedge clk) begin
        if (issue_fire)
            e_uop <= issue_uop;
        if (w_load)
            w_rec <= e_result;
    end

    always_comb begin
        raddr.raddr0 = e_uop.src0_preg;
        raddr.raddr1 = e_uop.src1_preg;
    end

    assign cpl_valid = (w_state == W_FULL);
    assign cpl       = w_rec;

    // forward the pending result until it lands in the prf
    always_comb begin
        bypass.valid = (w_state == W_FULL) && w_rec.dst_we;
        bypass.preg  = w_rec.dst_preg;
        bypass.data  = w_rec.data;
        prf_wr.we    = w_done && w_rec.dst_we;  // same edge as completion
        prf_wr.preg  = w_rec.dst_preg;
        prf_wr.data  = w_rec.data;
    end

endmodule

// ==== source/exec_defines.svh ====
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// datapath word width
`define EXEC_XLEN 32

// physical register number, 64 entries
`define EXEC_PREG_BITS 6

// reorder buffer slot id, 32 slots
`define EXEC_ROB_BITS 5

// derived sizes
`define EXEC_PREG_COUNT (1 << `EXEC_PREG_BITS)
`define EXEC_SHAMT_BITS 5

`endif

// ==== source/exec_top.sv ====
`timescale 1ns/100ps

module exec_top (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          issue_valid,
    output logic          issue_ready,
    input  uop_pkg::uop_t issue_uop,
    output logic          cpl_valid,
    input  logic          cpl_ready,
    output uop_pkg::cpl_t cpl
);

    import prf_pkg::*;
    import uop_pkg::*;

    uop_t       e_uop;
    cpl_t       e_result;
    prf_raddr_t raddr;
    prf_rdata_t rdata;
    bypass_t    bypass;
    prf_wr_t    prf_wr;

    exec_ctrl ctrl_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop),
        .cpl_valid   (cpl_valid),
        .cpl_ready   (cpl_ready),
        .cpl         (cpl),
        .e_uop       (e_uop),
        .raddr       (raddr),
        .e_result    (e_result),
        .bypass      (bypass),
        .prf_wr      (prf_wr)
    );

    phys_regfile prf_i (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (raddr),
        .rdata  (rdata),
        .wr     (prf_wr)
    );

    int_alu alu_i (
        .uop    (e_uop),
        .rdata  (rdata),
        .bypass (bypass),
        .result (e_result)
    );

endmodule

// ==== source/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
    input  uop_pkg::uop_t       uop,
    input  prf_pkg::prf_rdata_t rdata,
    input  prf_pkg::bypass_t    bypass,
    output uop_pkg::cpl_t       result
);

    import prf_pkg::*;
    import uop_pkg::*;

    localparam int MSB = $bits(word_t) - 1;

    logic       byp0;
    logic       byp1;
    word_t      src0;
    word_t      src1;
    logic       sub;
    word_t      addend;
    word_t      sum;
    logic       ovf;
    logic [4:0] shamt;
    word_t      count;
    word_t      res;

    // forwarding only for operands actually read
    assign byp0 = bypass.valid && uop.src0_re && (bypass.preg == uop.src0_preg);
    assign byp1 = bypass.valid && uop.src1_re && (bypass.preg == uop.src1_preg);

    always_comb begin
        if (byp0)
            src0 = bypass.data;
        else if (uop.src0_re)
            src0 = rdata.rdata0;
        else
            src0 = '0;
    end

    always_comb begin
        if (byp1)
            src1 = bypass.data;
        else if (uop.src1_re)
            src1 = rdata.rdata1;
        else
            src1 = uop.imm;     // immediate forms
    end

    // shared adder, subtract as add of inverted plus one
    assign sub    = (uop.op == SUB) || (uop.op == SUBU);
    assign addend = sub ? ~src1 : src1;
    assign sum    = src0 + addend + word_t'(sub);

    // signed overflow, only the trapping forms report it
    assign ovf = ((uop.op == ADD) || (uop.op == SUB))
              && (src0[MSB] == addend[MSB])
              && (sum[MSB] != src0[MSB]);

    assign shamt = src0[4:0];

    lead_count lc_i (
        .word       (src0),
        .count_ones (uop.op == CLO),
        .count      (count)
    );

    always_comb begin
        case (uop.op)
            ADD, ADDU, SUB, SUBU: res = sum;
            SLT:  res = word_t'($signed(src0) < $signed(src1));
            SLTU: res = word_t'(src0 < src1);
            AND:  res = src0 & src1;
            OR:   res = src0 | src1;
            XOR:  res = src0 ^ src1;
            NOR:  res = ~(src0 | src1);
            SLL:  res = src1 << shamt;
            SRL:  res = src1 >> shamt;
            SRA:  res = word_t'($signed(src1) >>> shamt);
            CLZ, CLO: res = count;
            MOVE: res = src0;
            LINK: res = uop.pc + word_t'(8);
            default: res = '0;
        endcase
    end

    always_comb begin
        result.id       = uop.id;
        result.dst_preg = uop.dst_preg;
        result.dst_we   = uop.dst_we && !ovf;  // overflowed result is dropped
        result.overflow = ovf;
        result.data     = res;
    end

endmodule

// ==== source/lead_count.sv ====
`timescale 1ns/100ps

module lead_count (
    input  prf_pkg::word_t word,
    input  logic           count_ones,
    output prf_pkg::word_t count
);

    import prf_pkg::*;

    localparam int W = $bits(word_t);

    logic hit;

    // scan from msb until a bit differs from the counted value
    always_comb begin
        hit   = 1'b0;
        count = '0;
        for (int i = W - 1; i >= 0; i--) begin
            if (!hit) begin
                if (word[i] != count_ones)
                    hit = 1'b1;
                else
                    count = count + 1'b1;
            end
        end
    end

endmodule

// ==== source/phys_regfile.sv ====
`timescale 1ns/100ps
`include "exec_defines.svh"

module phys_regfile (
    input  logic                clk,
    input  logic                arst_n,
    input  prf_pkg::prf_raddr_t raddr,
    output prf_pkg::prf_rdata_t rdata,
    input  prf_pkg::prf_wr_t    wr
);

    import prf_pkg::*;

    word_t regs [`EXEC_PREG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `EXEC_PREG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we) begin
            regs[wr.preg] <= wr.data;
        end
    end

    // old value on a same-cycle write, bypass handles it
    always_comb begin
        rdata.rdata0 = regs[raddr.raddr0];
        rdata.rdata1 = regs[raddr.raddr1];
    end

endmodule

// ==== source/prf_pkg.sv ====
`include "exec_defines.svh"

package prf_pkg;

    typedef logic [`EXEC_XLEN-1:0]      word_t;
    typedef logic [`EXEC_PREG_BITS-1:0] preg_t;

    typedef struct packed {
        preg_t raddr0;
        preg_t raddr1;
    } prf_raddr_t;

    typedef struct packed {
        word_t rdata0;
        word_t rdata1;
    } prf_rdata_t;

    // whole read port, address half plus data half
    typedef struct packed {
        prf_raddr_t addr;
        prf_rdata_t data;
    } prf_rd_t;

    typedef struct packed {
        logic  we;
        preg_t preg;
        word_t data;
    } prf_wr_t;

    typedef struct packed {
        logic  valid;
        preg_t preg;
        word_t data;
    } bypass_t;

endpackage

// ==== source/uop_pkg.sv ====
`include "exec_defines.svh"

package uop_pkg;

    import prf_pkg::*;

    typedef logic [`EXEC_ROB_BITS-1:0] rob_id_t;

    // immediate forms reuse these with src1_re cleared
    typedef enum logic [4:0] {
        ADD,
        ADDU,
        SUB,
        SUBU,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        NOR,
        SLL,
        SRL,
        SRA,
        CLZ,
        CLO,
        MOVE,
        LINK    // pc + 8
    } uop_e;

    typedef struct packed {
        rob_id_t id;
        uop_e    op;
        word_t   pc;
        preg_t   src0_preg;
        logic    src0_re;
        preg_t   src1_preg;
        logic    src1_re;
        word_t   imm;
        preg_t   dst_preg;
        logic    dst_we;
    } uop_t;

    typedef struct packed {
        rob_id_t id;
        preg_t   dst_preg;
        logic    dst_we;     // already cleared on overflow
        logic    overflow;
        word_t   data;
    } cpl_t;

endpackage

// ==== verif/exec_asserts.sv ====
`timescale 1ns/100ps

module exec_asserts (
    input logic             clk,
    input logic             arst_n,
    input logic             cpl_valid,
    input logic             cpl_ready,
    input uop_pkg::cpl_t    cpl,
    input prf_pkg::prf_wr_t prf_wr
);

    // a stalled completion keeps valid and payload
    cpl_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl)
    ) else $error("completion dropped or changed while stalled");

    cpl_idle_in_reset: assert property (
        @(posedge clk) !arst_n |-> !cpl_valid
    ) else $error("cpl_valid high during reset");

    write_needs_transfer: assert property (
        @(posedge clk) disable iff (!arst_n)
        prf_wr.we |-> cpl_valid && cpl_ready
    ) else $error("register write without a completion transfer");

endmodule

bind exec_ctrl exec_asserts asserts_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cpl_valid   (cpl_valid),
    .cpl_ready   (cpl_ready),
    .cpl         (cpl),
    .prf_wr      (prf_wr)
);

// ==== verif/exec_tb.sv ====
`timescale 1ns/100ps
`include "exec_defines.svh"

module exec_tb;

    import prf_pkg::*;
    import uop_pkg::*;

    localparam int N_DIRECTED   = 20;
    localparam int N_RANDOM     = 400;
    localparam int N_OPS        = N_DIRECTED + N_RANDOM;
    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 4;
    localparam int WATCHDOG_NS  = N_OPS * 8 * CLK_NS + RESET_CYCLES * CLK_NS;

    logic    clk;
    logic    arst_n;
    logic    issue_valid;
    logic    issue_ready;
    uop_t    issue_uop;
    logic    cpl_valid;
    logic    cpl_ready;
    cpl_t    cpl;

    logic [15:0] lfsr;
    word_t       mirror [`EXEC_PREG_COUNT];    // prf contents after all predicted ops
    cpl_t        exp_q [$];
    rob_id_t     next_id;
    int          n_issued;
    int          n_done;

    exec_top dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_uop   (issue_uop),
        .cpl_valid   (cpl_valid),
        .cpl_ready   (cpl_ready),
        .cpl         (cpl)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // galois lfsr x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic cpl_t predict(uop_t u);
        cpl_t        c;
        word_t       a;
        word_t       b;
        logic [32:0] wide;
        int          sh;
        int          n;
        a    = u.src0_re ? mirror[u.src0_preg] : '0;
        b    = u.src1_re ? mirror[u.src1_preg] : u.imm;
        sh   = int'(a[4:0]);
        wide = '0;
        n    = 0;
        case (u.op)
            ADD, ADDU: begin
                wide   = {a[31], a} + {b[31], b};
                c.data = wide[31:0];
            end
            SUB, SUBU: begin
                wide   = {a[31], a} - {b[31], b};
                c.data = wide[31:0];
            end
            SLT:  c.data = {31'b0, $signed(a) < $signed(b)};
            SLTU: c.data = {31'b0, a < b};
            AND:  c.data = a & b;
            OR:   c.data = a | b;
            XOR:  c.data = a ^ b;
            NOR:  c.data = ~(a | b);
            SLL:  c.data = b << sh;
            SRL:  c.data = b >> sh;
            SRA:  c.data = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            CLZ, CLO: begin
                while (n < 32 && a[31 - n] == (u.op == CLO))
                    n++;
                c.data = word_t'(n);
            end
            MOVE: c.data = a;
            LINK: c.data = u.pc + 32'd8;
            default: c.data = '0;
        endcase
        c.id       = u.id;
        c.dst_preg = u.dst_preg;
        c.overflow = ((u.op == ADD) || (u.op == SUB)) && (wide[32] != wide[31]);
        c.dst_we   = u.dst_we && !c.overflow;
        return c;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_preg(string name, preg_t exp, preg_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(string name, rob_id_t exp, rob_id_t act);
        if (exp !== act) begin
            $display("MISMATCH at %0t ns: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("MISMATCH at %0t ns: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic uop_t make_uop(uop_e op, int s0, logic re0, int s1, logic re1,
                                      word_t imm, int dst);
        uop_t u;
        u.id        = '0;
        u.op        = op;
        u.pc        = rand_bits(30) << 2;
        u.src0_preg = preg_t'(s0);
        u.src0_re   = re0;
        u.src1_preg = preg_t'(s1);
        u.src1_re   = re1;
        u.imm       = imm;
        u.dst_preg  = preg_t'(dst);
        u.dst_we    = 1'b1;
        return u;
    endfunction

    function automatic uop_t random_uop();
        uop_t u;
        uop_e op;
        int   s0;
        int   s1;
        int   dst;
        logic re0;
        logic re1;
        op  = uop_e'(5'(rand_bits(5) % 17));
        s0  = int'(rand_bits(4));   // few registers so many dependencies
        re0 = rand_bits(3) != 0;
        s1  = int'(rand_bits(4));
        re1 = rand_bits(1) != 0;
        dst = int'(rand_bits(4));
        u   = make_uop(op, s0, re0, s1, re1, rand_bits(32), dst);
        u.dst_we = rand_bits(3) != 0;
        return u;
    endfunction

    task automatic record_issue(uop_t u);
        cpl_t p;
        p = predict(u);
        exp_q.push_back(p);
        if (p.dst_we)
            mirror[p.dst_preg] = p.data;
        n_issued++;
    endtask

    // entered and left 1 ns after a rising edge
    task automatic issue_op(uop_t u, logic stalls);
        logic sent;
        sent = 1'b0;
        u.id = next_id;
        next_id++;
        issue_uop   = u;
        issue_valid = 1'b1;
        while (!sent) begin
            @(negedge clk);
            if (issue_ready) begin
                record_issue(u);
                sent = 1'b1;
            end
            @(posedge clk);
            #1;
            if (stalls)
                cpl_ready = (rand_bits(2) != 0);
        end
        issue_valid = 1'b0;
    endtask

    always @(negedge clk) begin
        cpl_t exp_rec;
        if (arst_n && cpl_valid && cpl_ready) begin
            if (exp_q.size() == 0) begin
                $display("completion at %0t ns with no micro-op outstanding", $time);
                abort_run();
            end else begin
                exp_rec = exp_q.pop_front();
                check_id("cpl.id", exp_rec.id, cpl.id);
                check_preg("cpl.dst_preg", exp_rec.dst_preg, cpl.dst_preg);
                check_flag("cpl.dst_we", exp_rec.dst_we, cpl.dst_we);
                check_flag("cpl.overflow", exp_rec.overflow, cpl.overflow);
                check_word("cpl.data", exp_rec.data, cpl.data);
                n_done++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, completions stopped at %0d of %0d", n_done, N_OPS);
        abort_run();
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue_uop   = '0;
        cpl_ready   = 1'b0;
        lfsr        = 16'd48288;
        next_id     = '0;
        n_issued    = 0;
        n_done      = 0;
        foreach (mirror[i])
            mirror[i] = '0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_flag("issue_ready", 1'b0, issue_ready);   // both streams idle in reset
            check_flag("cpl_valid", 1'b0, cpl_valid);
        end
        arst_n    = 1'b1;
        cpl_ready = 1'b1;

        issue_op(make_uop(OR, 0, 1'b0, 0, 1'b0, 32'h0, 1), 1'b0);
        issue_op(make_uop(OR, 9, 1'b1, 10, 1'b1, 32'h0, 2), 1'b0);  // cleared prf
        issue_op(make_uop(OR, 0, 1'b0, 0, 1'b0, 32'h8000_0000, 1), 1'b0);
        issue_op(make_uop(ADDU, 0, 1'b0, 0, 1'b0, 32'h7fff_ffff, 2), 1'b0);
        issue_op(make_uop(OR, 0, 1'b0, 0, 1'b0, 32'h0000_1234, 3), 1'b0);
        issue_op(make_uop(ADD, 2, 1'b1, 0, 1'b0, 32'h1, 3), 1'b0);  // overflows
        issue_op(make_uop(MOVE, 3, 1'b1, 0, 1'b0, 32'h0, 4), 1'b0);
        issue_op(make_uop(SUB, 1, 1'b1, 0, 1'b0, 32'h1, 5), 1'b0);  // overflows
        issue_op(make_uop(OR, 0, 1'b0, 0, 1'b0, 32'h4, 7), 1'b0);
        issue_op(make_uop(SRA, 7, 1'b1, 1, 1'b1, 32'h0, 6), 1'b0);
        issue_op(make_uop(SRL, 7, 1'b1, 1, 1'b1, 32'h0, 8), 1'b0);
        issue_op(make_uop(SLT, 1, 1'b1, 7, 1'b1, 32'h0, 9), 1'b0);
        issue_op(make_uop(SLTU, 1, 1'b1, 7, 1'b1, 32'h0, 10), 1'b0);
        issue_op(make_uop(NOR, 0, 1'b0, 0, 1'b0, 32'h0, 11), 1'b0);
        issue_op(make_uop(CLO, 11, 1'b1, 0, 1'b0, 32'h0, 12), 1'b0);
        issue_op(make_uop(CLZ, 0, 1'b1, 0, 1'b0, 32'h0, 13), 1'b0);
        issue_op(make_uop(CLZ, 11, 1'b1, 0, 1'b0, 32'h0, 14), 1'b0);
        issue_op(make_uop(LINK, 0, 1'b0, 0, 1'b0, 32'h0, 15), 1'b0);
        issue_op(make_uop(AND, 6, 1'b1, 0, 1'b0, 32'hffff_0000, 16), 1'b0);
        issue_op(make_uop(XOR, 6, 1'b1, 11, 1'b1, 32'h0, 17), 1'b0);

        for (int k = 0; k < N_RANDOM; k++) begin
            while (rand_bits(2) == 0) begin    // issue gap
                @(posedge clk);
                #1;
                cpl_ready = (rand_bits(2) != 0);
            end
            issue_op(random_uop(), 1'b1);
        end
        cpl_ready = 1'b1;

        wait (n_done == n_issued);
        repeat (4) @(posedge clk);
        if (exp_q.size() == 0 && n_done == N_OPS) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("wrong completion count at the end: %0d of %0d", n_done, N_OPS);
            abort_run();
        end
    end

endmodule
